/* build.f */
+incdir+tests
common/asym_fifo_pkg.sv
asym_mem/asym_mem_tile.sv
asym_mem/asym_mem_tiled.sv
verilog/asym_fifo_ctrl.sv
verilog/asym_fifo.sv
tests/tb_asym_fifo.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the asym_fifo testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f build.f --top-module tb_asym_fifo --Mdir obj_dir -o sim_asym_fifo

# the pass line decides the result, not the exit code
sim_out="$(./obj_dir/sim_asym_fifo 2>&1)" || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "Test completed successfully"; then
    exit 0
else
    exit 1
fi

/* tests/tb_asym_fifo_checks.svh */
`ifndef TB_ASYM_FIFO_CHECKS_SVH
`define TB_ASYM_FIFO_CHECKS_SVH

// outputs straight after a reset edge
a_reset_state: assert property (
    @(posedge clk) rst_d |-> (empty && !full && count == '0
                              && !rd_valid && !overflow && !underflow)
) else stop_on_error($sformatf(
    "mismatch reset: expected empty/full/count/pulses 1/0/0/000 actual %b/%b/%0d/%b%b%b",
    $sampled(empty), $sampled(full), $sampled(count),
    $sampled(rd_valid), $sampled(overflow), $sampled(underflow)));

// rd_valid exactly one cycle after an accepted pop, never after a refused one
a_rd_valid: assert property (
    @(posedge clk) disable iff (rst) rd_valid == exp_valid
) else stop_on_error($sformatf("mismatch %s rd_valid: expected %b actual %b",
                               phase_name, $sampled(exp_valid), $sampled(rd_valid)));

// lane order through every tile
a_rd_data: assert property (
    @(posedge clk) disable iff (rst) exp_valid |-> rd_data === exp_data
) else stop_on_error($sformatf("mismatch %s rd_data: expected %h actual %h",
                               phase_name, $sampled(exp_data), $sampled(rd_data)));

// occupancy in narrow words
a_count: assert property (
    @(posedge clk) disable iff (rst) int'(count) == model_cnt
) else stop_on_error($sformatf("mismatch %s count: expected %0d actual %0d",
                               phase_name, $sampled(model_cnt), $sampled(count)));

a_full: assert property (
    @(posedge clk) disable iff (rst) full == (model_cnt > PUSH_MAX)
) else stop_on_error($sformatf("mismatch %s full: expected %b actual %b",
                               phase_name, $sampled(model_cnt) > PUSH_MAX, $sampled(full)));

a_empty: assert property (
    @(posedge clk) disable iff (rst) empty == (model_cnt == 0)
) else stop_on_error($sformatf("mismatch %s empty: expected %b actual %b",
                               phase_name, $sampled(model_cnt) == 0, $sampled(empty)));

// one cycle pulse per refused push
a_overflow: assert property (
    @(posedge clk) disable iff (rst) overflow == exp_ovf
) else stop_on_error($sformatf("mismatch %s overflow: expected %b actual %b",
                               phase_name, $sampled(exp_ovf), $sampled(overflow)));

// one cycle pulse per refused pop
a_underflow: assert property (
    @(posedge clk) disable iff (rst) underflow == exp_unf
) else stop_on_error($sformatf("mismatch %s underflow: expected %b actual %b",
                               phase_name, $sampled(exp_unf), $sampled(underflow)));

`endif

/* tests/tb_asym_fifo.sv */
module tb_asym_fifo;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DW_A        = asym_fifo_pkg::DEF_DATA_W_A;
    localparam int DW_B        = asym_fifo_pkg::DEF_DATA_W_B;
    localparam int DEPTH_B     = asym_fifo_pkg::DEF_DEPTH_B;
    localparam int TILE_ADDR_W = asym_fifo_pkg::DEF_TILE_ADDR_W;
    localparam int RATIO       = asym_fifo_pkg::ratio_of(DW_A, DW_B);
    localparam int ADDR_W_B    = $clog2(DEPTH_B);
    localparam int PUSH_MAX    = DEPTH_B - RATIO;           // last count that still takes a push
    localparam int MIX_CYCLES  = 2000;
    localparam int TIMEOUT_CYC = 8 * DEPTH_B + 2000;        // two fills, two drains, mix, slack
    localparam logic [31:0] SEED = 32'h60f;

    logic              clk;
    logic              rst;
    logic              push;
    logic              pop;
    logic [DW_A-1:0]   wr_data;
    logic [DW_B-1:0]   rd_data;
    logic              rd_valid;
    logic              full;
    logic              empty;
    logic [ADDR_W_B:0] count;
    logic              overflow;
    logic              underflow;

    // reference model, narrow words in pop order
    logic [DW_B-1:0] model_q [$];
    int              model_cnt = 0;     // model size after the last edge
    logic [DW_B-1:0] exp_data;          // head taken by the last accepted pop
    logic            exp_valid;
    logic            exp_ovf;
    logic            exp_unf;
    logic            push_ok;
    logic            pop_ok;
    logic            rst_d = 1'b0;      // reset seen at the previous edge

    string phase_name = "reset";
    int    cycles     = 0;

    asym_fifo #(
        .DATA_W_A    (DW_A),
        .DATA_W_B    (DW_B),
        .DEPTH_B     (DEPTH_B),
        .TILE_ADDR_W (TILE_ADDR_W)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .wr_data   (wr_data),
        .pop       (pop),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .full      (full),
        .empty     (empty),
        .count     (count),
        .overflow  (overflow),
        .underflow (underflow)
    );

    always #10 clk = ~clk;  // 20 ns period

    // report, then stop the run
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "run stopped at first error");
    endtask

    `include "tb_asym_fifo_checks.svh"

    // model sees the same pre-edge inputs as the DUT
    always @(posedge clk) begin
        if (rst) begin
            model_q.delete();
            model_cnt <= 0;
            exp_valid <= 1'b0;
            exp_ovf   <= 1'b0;
            exp_unf   <= 1'b0;
        end else begin
            push_ok = push && (model_q.size() <= PUSH_MAX);
            pop_ok  = pop && (model_q.size() != 0);     // judged before this edge's push
            if (pop_ok) begin
                exp_data <= model_q.pop_front();
            end
            if (push_ok) begin
                for (int j = 0; j < RATIO; j++) begin
                    model_q.push_back(wr_data[j*DW_B +: DW_B]);  // low lane first
                end
            end
            model_cnt <= model_q.size();
            exp_valid <= pop_ok;
            exp_ovf   <= push && !push_ok;
            exp_unf   <= pop && !pop_ok;
        end
        rst_d <= rst;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            stop_on_error($sformatf("timeout: run still busy after %0d cycles", cycles));
        end
    end

    function automatic logic [DW_A-1:0] random_word();
        logic [DW_A-1:0] w;
        w = '0;
        for (int i = 0; i < (DW_A + 31) / 32; i++) begin
            w = (w << 32) | DW_A'($urandom);
        end
        return w;
    endfunction

    // back to back pushes, stops once the pending push makes it full
    task automatic fill_to_full();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(posedge clk);
            busy = (int'(count) + RATIO * int'(push)) <= PUSH_MAX;
            push    <= busy;
            wr_data <= random_word();
        end
    endtask

    // back to back pops, the pop in flight counts as already taken
    task automatic drain_to_empty();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(posedge clk);
            busy = int'(count) > int'(pop);
            pop <= busy;
        end
    endtask

    task automatic run_random_mix(input int n);
        repeat (n) begin
            @(posedge clk);
            push    <= ($urandom % 3) == 0;     // two narrow words in
            pop     <= ($urandom % 3) != 0;     // about as many out
            wr_data <= random_word();
        end
        @(posedge clk);
        push <= 1'b0;
        pop  <= 1'b0;
    endtask

    // single refused strobes with a gap
    task automatic push_while_full(input int n);
        repeat (n) begin
            @(posedge clk);
            push    <= 1'b1;
            wr_data <= random_word();
            @(posedge clk);
            push <= 1'b0;
            @(posedge clk);
        end
    endtask

    task automatic pop_while_empty(input int n);
        repeat (n) begin
            @(posedge clk);
            pop <= 1'b1;
            @(posedge clk);
            pop <= 1'b0;
            @(posedge clk);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    initial begin
        void'($urandom(SEED));
        clk     = 1'b0;
        rst     = 1'b1;
        push    = 1'b0;
        pop     = 1'b0;
        wr_data = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        phase_name = "fill";
        fill_to_full();
        idle_cycles(3);
        phase_name = "drain";
        drain_to_empty();
        idle_cycles(3);
        phase_name = "random_mix";
        run_random_mix(MIX_CYCLES);
        idle_cycles(3);
        phase_name = "overflow";
        fill_to_full();
        idle_cycles(2);
        push_while_full(3);
        phase_name = "underflow";
        drain_to_empty();
        idle_cycles(2);
        pop_while_empty(3);
        idle_cycles(3);     // let the last pulses reach the checks

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* verilog/asym_fifo.sv */
module asym_fifo #(
    parameter int DATA_W_A    = asym_fifo_pkg::DEF_DATA_W_A,     // push width
    parameter int DATA_W_B    = asym_fifo_pkg::DEF_DATA_W_B,     // pop width
    parameter int DEPTH_B     = asym_fifo_pkg::DEF_DEPTH_B,      // narrow words
    parameter int TILE_ADDR_W = asym_fifo_pkg::DEF_TILE_ADDR_W,
    localparam int RATIO      = asym_fifo_pkg::ratio_of(DATA_W_A, DATA_W_B),
    localparam int ADDR_W_B   = $clog2(DEPTH_B),
    localparam int ADDR_W_A   = ADDR_W_B - $clog2(RATIO)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,       // strobe
    input  logic [DATA_W_A-1:0] wr_data,
    input  logic                pop,        // strobe
    output logic [DATA_W_B-1:0] rd_data,
    output logic                rd_valid,   // one cycle after an accepted pop
    output logic                full,
    output logic                empty,
    output logic [ADDR_W_B:0]   count,
    output logic                overflow,
    output logic                underflow
);

    // controller to memory
    logic                mem_w_en;
    logic [ADDR_W_A-1:0] mem_w_addr;
    logic                mem_r_en;
    logic [ADDR_W_B-1:0] mem_r_addr;

    // pointers, occupancy and status
    asym_fifo_ctrl #(
        .DATA_W_A (DATA_W_A),
        .DATA_W_B (DATA_W_B),
        .DEPTH_B  (DEPTH_B)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .pop        (pop),
        .mem_w_en   (mem_w_en),
        .mem_w_addr (mem_w_addr),
        .mem_r_en   (mem_r_en),
        .mem_r_addr (mem_r_addr),
        .rd_valid   (rd_valid),
        .full       (full),
        .empty      (empty),
        .count      (count),
        .overflow   (overflow),
        .underflow  (underflow)
    );

    // storage, wide write side and narrow registered read side
    asym_mem_tiled #(
        .DATA_W_A    (DATA_W_A),
        .DATA_W_B    (DATA_W_B),
        .DEPTH_B     (DEPTH_B),
        .TILE_ADDR_W (TILE_ADDR_W)
    ) u_mem (
        .clk    (clk),
        .w_en   (mem_w_en),
        .w_addr (mem_w_addr),
        .w_data (wr_data),      // straight from the port
        .r_en   (mem_r_en),
        .r_addr (mem_r_addr),
        .r_data (rd_data)
    );

endmodule

/* verilog/asym_fifo_ctrl.sv */
module asym_fifo_ctrl #(
    parameter int DATA_W_A  = asym_fifo_pkg::DEF_DATA_W_A,
    parameter int DATA_W_B  = asym_fifo_pkg::DEF_DATA_W_B,
    parameter int DEPTH_B   = asym_fifo_pkg::DEF_DEPTH_B,
    localparam int RATIO    = asym_fifo_pkg::ratio_of(DATA_W_A, DATA_W_B),
    localparam int ADDR_W_B = $clog2(DEPTH_B),
    localparam int ADDR_W_A = ADDR_W_B - $clog2(RATIO)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  logic                pop,
    output logic                mem_w_en,
    output logic [ADDR_W_A-1:0] mem_w_addr,
    output logic                mem_r_en,
    output logic [ADDR_W_B-1:0] mem_r_addr,
    output logic                rd_valid,
    output logic                full,
    output logic                empty,
    output logic [ADDR_W_B:0]   count,      // occupancy in narrow words
    output logic                overflow,
    output logic                underflow
);

    localparam int CNT_W    = ADDR_W_B + 1;
    localparam int PUSH_MAX = DEPTH_B - RATIO;  // highest count that still fits a wide word

    logic [ADDR_W_A-1:0] wr_ptr;    // wide slot, wraps naturally
    logic [ADDR_W_B-1:0] rd_ptr;    // narrow word, wraps naturally
    logic                push_acc;
    logic                pop_acc;

    // levels straight from the counter
    assign full  = count > CNT_W'(PUSH_MAX);
    assign empty = count == '0;

    assign push_acc = push && !full;
    assign pop_acc  = pop && !empty;

    // wr_ptr * ratio and rd_ptr index the same narrow space
    assign mem_w_en   = push_acc;
    assign mem_w_addr = wr_ptr;
    assign mem_r_en   = pop_acc;
    assign mem_r_addr = rd_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (push_acc) begin
            wr_ptr <= wr_ptr + ADDR_W_A'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (pop_acc) begin
            rd_ptr <= rd_ptr + ADDR_W_B'(1);
        end
    end

    // push adds ratio narrow words, pop takes one
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push_acc, pop_acc})
                2'b10:   count <= count + CNT_W'(RATIO);
                2'b01:   count <= count - CNT_W'(1);
                2'b11:   count <= count + CNT_W'(RATIO - 1);
                default: count <= count;
            endcase
        end
    end

    // status pulses, one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid  <= 1'b0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            rd_valid  <= pop_acc;       // matches the registered tile read
            overflow  <= push && full;  // refused push is lost
            underflow <= pop && empty;
        end
    end

    // occupancy bound holds over any push/pop sequence
    a_count_max: assert property (
        @(posedge clk) disable iff (rst) count <= CNT_W'(DEPTH_B)
    ) else $error("asym_fifo_ctrl: count above depth");

    // memory enables stay off while blocked
    a_no_w_full: assert property (
        @(posedge clk) disable iff (rst) full |-> !mem_w_en
    ) else $error("asym_fifo_ctrl: write while full");

    a_no_r_empty: assert property (
        @(posedge clk) disable iff (rst) empty |-> !mem_r_en
    ) else $error("asym_fifo_ctrl: read while empty");

endmodule

/* asym_mem/asym_mem_tiled.sv */
module asym_mem_tiled #(
    parameter int DATA_W_A    = asym_fifo_pkg::DEF_DATA_W_A,
    parameter int DATA_W_B    = asym_fifo_pkg::DEF_DATA_W_B,
    parameter int DEPTH_B     = asym_fifo_pkg::DEF_DEPTH_B,
    parameter int TILE_ADDR_W = asym_fifo_pkg::DEF_TILE_ADDR_W,
    localparam int RATIO      = asym_fifo_pkg::ratio_of(DATA_W_A, DATA_W_B),
    localparam int ADDR_W_B   = $clog2(DEPTH_B),
    localparam int ADDR_W_A   = ADDR_W_B - $clog2(RATIO)
) (
    input  logic                clk,
    input  logic                w_en,
    input  logic [ADDR_W_A-1:0] w_addr,
    input  logic [DATA_W_A-1:0] w_data,
    input  logic                r_en,
    input  logic [ADDR_W_B-1:0] r_addr,
    output logic [DATA_W_B-1:0] r_data
);

    localparam int TILE_WORDS = 2 ** TILE_ADDR_W;
    localparam int N_TILES    = DEPTH_B / TILE_WORDS;
    localparam int SEL_W      = $clog2(N_TILES);        // top address bits pick the tile
    localparam int T_W_ADDR_W = ADDR_W_A - SEL_W;       // wide slot within a tile

    // geometry sanity at elaboration
    if (DEPTH_B % TILE_WORDS != 0 || N_TILES < 2) begin : g_bad_geometry
        $error("asym_mem_tiled: depth must be a multiple of the tile, at least 2 tiles");
    end

    logic [SEL_W-1:0]    w_sel;
    logic [SEL_W-1:0]    r_sel;
    logic [SEL_W-1:0]    r_sel_q;     // tile index of the read in flight
    logic [N_TILES-1:0]  w_tile_en;
    logic [N_TILES-1:0]  r_tile_en;
    logic [DATA_W_B-1:0] tile_rd [N_TILES];

    assign w_sel = w_addr[ADDR_W_A-1 -: SEL_W];
    assign r_sel = r_addr[ADDR_W_B-1 -: SEL_W];

    // one-hot tile enables
    always_comb begin
        w_tile_en        = '0;
        r_tile_en        = '0;
        w_tile_en[w_sel] = w_en;
        r_tile_en[r_sel] = r_en;
    end

    for (genvar t = 0; t < N_TILES; t++) begin : g_tile
        asym_mem_tile #(
            .DATA_W_A    (DATA_W_A),
            .DATA_W_B    (DATA_W_B),
            .TILE_ADDR_W (TILE_ADDR_W)
        ) u_tile (
            .clk    (clk),
            .w_en   (w_tile_en[t]),
            .w_addr (w_addr[T_W_ADDR_W-1:0]),   // low bits shared by all tiles
            .w_data (w_data),
            .r_en   (r_tile_en[t]),
            .r_addr (r_addr[TILE_ADDR_W-1:0]),
            .r_data (tile_rd[t])
        );
    end

    // tile outputs are registered, so the select follows one cycle behind
    always_ff @(posedge clk) begin
        if (r_en) begin
            r_sel_q <= r_sel;
        end
    end

    assign r_data = tile_rd[r_sel_q];   // output mux

    // at most one tile may take a write
    a_w_onehot: assert property (
        @(posedge clk) $onehot0(w_tile_en)
    ) else $error("asym_mem_tiled: more than one tile write enabled");

endmodule

/* asym_mem/asym_mem_tile.sv */
module asym_mem_tile #(
    parameter int DATA_W_A    = asym_fifo_pkg::DEF_DATA_W_A,
    parameter int DATA_W_B    = asym_fifo_pkg::DEF_DATA_W_B,
    parameter int TILE_ADDR_W = asym_fifo_pkg::DEF_TILE_ADDR_W,
    localparam int RATIO      = asym_fifo_pkg::ratio_of(DATA_W_A, DATA_W_B),
    localparam int LANE_W     = $clog2(RATIO),
    localparam int W_ADDR_W   = TILE_ADDR_W - LANE_W
) (
    input  logic                   clk,
    input  logic                   w_en,
    input  logic [W_ADDR_W-1:0]    w_addr,  // wide slot inside this tile
    input  logic [DATA_W_A-1:0]    w_data,
    input  logic                   r_en,
    input  logic [TILE_ADDR_W-1:0] r_addr,  // narrow word inside this tile
    output logic [DATA_W_B-1:0]    r_data
);

    localparam int TILE_WORDS = 2 ** TILE_ADDR_W;

    // storage kept as narrow words
    logic [DATA_W_B-1:0] mem [TILE_WORDS];

    // tracks which narrow words hold data, only the read check looks at it
    logic [TILE_WORDS-1:0] written = '0;

    // one wide write fills ratio consecutive narrow words
    // lane j lands at w_addr*ratio + j
    always_ff @(posedge clk) begin
        if (w_en) begin
            for (int j = 0; j < RATIO; j++) begin
                mem[int'(w_addr) * RATIO + j] <= w_data[j*DATA_W_B +: DATA_W_B];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (w_en) begin
            for (int j = 0; j < RATIO; j++) begin
                written[int'(w_addr) * RATIO + j] <= 1'b1;
            end
        end
    end

    // registered narrow read
    always_ff @(posedge clk) begin
        if (r_en) begin
            r_data <= mem[r_addr];
        end
        // r_data holds when idle so the tile mux sees a stable value
    end

    // data read from a filled word must come out clean one cycle later
    a_rd_known: assert property (
        @(posedge clk) r_en && written[r_addr] |=> !$isunknown(r_data)
    ) else $error("asym_mem_tile: unknown r_data after read of written word");

endmodule

/* common/asym_fifo_pkg.sv */
package asym_fifo_pkg;

    // default geometry of the buffer
    localparam int DEF_DATA_W_A    = 32;   // wide word pushed by producer
    localparam int DEF_DATA_W_B    = 16;   // narrow word popped by consumer
    localparam int DEF_DEPTH_B     = 512;  // capacity counted in narrow words
    localparam int DEF_TILE_ADDR_W = 7;    // narrow words per tile is 2**7

    // with the defaults above
    // ratio 2, 256 wide slots, 4 tiles of 128 narrow words

    // narrow lanes carried by one wide word
    // both widths are powers of two and data_w_a >= data_w_b,
    // so the division is always exact
    function automatic int ratio_of(input int data_w_a, input int data_w_b);
        int r;
        r = data_w_a / data_w_b;
        if (r < 1) begin
            r = 1;  // guard against a swapped pair
        end
        return r;
    endfunction

    // lane 0 sits in the low bits of the wide word and is popped first,
    // the top lane comes out last

    // address widths are derived inside each module
    // adr_b = clog2(depth_b)
    // adr_a = adr_b - clog2(ratio)

endpackage
